// File: tests/aes_io_input.dat
// Columns: message, key, core delay in cycles, expected result (all hex)
// One transaction per line, the expected result is message XOR key
00000000000000000000000000000000 00000000000000000000000000000000 0 00000000000000000000000000000000
00112233445566778899aabbccddeeff 000102030405060708090a0b0c0d0e0f 5 00102030405060708090a0b0c0d0e0f0
69c4e0d86a7b0430d8cdb78070b4c55a ffffffffffffffffffffffffffffffff 2 963b1f279584fbcf2732487f8f4b3aa5
ffffffffffffffffffffffffffffffff 0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f 1 f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0
3243f6a8885a308d313198a2e0370734 00000000000000000000000000000000 7 3243f6a8885a308d313198a2e0370734
2b7e151628aed2a6abf7158809cf4f3c 2b7e151628aed2a6abf7158809cf4f3c 0 00000000000000000000000000000000
80000000000000000000000000000000 00000000000000000000000000000001 10 80000000000000000000000000000001
a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a 3 ffffffffffffffffffffffffffffffff
0123456789abcdef0123456789abcdef f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0 4 f1d3b597795b3d1ff1d3b597795b3d1f
11111111222222223333333344444444 01010101020202020303030304040404 6 10101010202020203030303040404040
deadbeefcafef00d0badc0de12345678 ffffffff00000000ffffffff00000000 2 21524110cafef00df4523f2112345678
00000000000000000000000000000000 8899aabbccddeeff0011223344556677 20 8899aabbccddeeff0011223344556677
fedcba98765432100123456789abcdef 00000000ffffffff00000000ffffffff 1 fedcba9889abcdef0123456776543210
55555555555555555555555555555555 0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f 0 5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a

// File: sources.f
design/aes_io_pkg.sv
design/host_io_fsm.sv
design/block_buffer.sv
design/aes_io_bridge.sv
tests/aes_io_monitor.sv
tests/tb_aes_io_bridge.sv

// File: Makefile
BIN  := obj_dir/Vtb_aes_io_bridge
SRCS := $(wildcard design/*.sv tests/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): sources.f $(SRCS)
	verilator --binary --assert --top-module tb_aes_io_bridge -f sources.f -o Vtb_aes_io_bridge

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/tb_aes_io_bridge.sv
// Testbench top for the AES host I/O bridge, vectors come from tests/aes_io_input.dat
`timescale 1ns/1ps

module tb_aes_io_bridge;

  // Processor flag and status codes
  localparam logic [1:0] cmd_load_msg = 2'd1;
  localparam logic [1:0] cmd_load_key = 2'd2;
  localparam logic [1:0] cmd_run      = 2'd3;
  localparam logic [1:0] flag_req     = 2'd1;
  localparam logic [1:0] stat_idle    = 2'd0;
  localparam logic [1:0] stat_ack     = 2'd1;
  localparam logic [1:0] stat_done    = 2'd2;

  localparam int reset_cycles    = 8;
  localparam int max_vecs        = 64;
  // Three commands and three blocks of bytes per transaction
  localparam int exch_per_vec    = 3 + 3 * aes_io_pkg::block_bytes;
  localparam int cycles_per_exch = 12;

  logic                            clk;
  logic                            reset_n;
  logic [1:0]                      to_hw_sig;
  logic [aes_io_pkg::byte_w-1:0]   to_hw_port;
  logic [aes_io_pkg::block_w-1:0]  msg_de;
  logic                            aes_ready;
  logic [1:0]                      to_sw_sig;
  logic [aes_io_pkg::byte_w-1:0]   to_sw_port;
  logic [aes_io_pkg::block_w-1:0]  msg_en;
  logic [aes_io_pkg::block_w-1:0]  key;
  logic                            io_ready;

  logic [aes_io_pkg::block_w-1:0]  exp_msg;
  logic [aes_io_pkg::block_w-1:0]  exp_key;
  logic [aes_io_pkg::block_w-1:0]  exp_result;
  logic                            check_blocks;
  logic                            check_result;
  int                              check_count;
  int                              mismatch_count;
  int                              handshake_errors;

  // Four words per transaction, the top bit stays set on words the file did not fill
  logic [aes_io_pkg::block_w:0]    vec_mem [0:4*max_vecs-1];
  int                              n_vecs;
  int                              limit_cycles;
  int                              core_delay;
  logic [31:0]                     lfsr;

  aes_io_bridge dut_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .to_hw_sig  (to_hw_sig),
    .to_hw_port (to_hw_port),
    .msg_de     (msg_de),
    .aes_ready  (aes_ready),
    .to_sw_sig  (to_sw_sig),
    .to_sw_port (to_sw_port),
    .msg_en     (msg_en),
    .key        (key),
    .io_ready   (io_ready)
  );

  aes_io_monitor mon_i (
    .clk              (clk),
    .reset_n          (reset_n),
    .to_hw_sig        (to_hw_sig),
    .to_sw_sig        (to_sw_sig),
    .to_sw_port       (to_sw_port),
    .msg_en           (msg_en),
    .key              (key),
    .io_ready         (io_ready),
    .aes_ready        (aes_ready),
    .check_blocks     (check_blocks),
    .check_result     (check_result),
    .exp_msg          (exp_msg),
    .exp_key          (exp_key),
    .exp_result       (exp_result),
    .check_count      (check_count),
    .mismatch_count   (mismatch_count),
    .handshake_errors (handshake_errors)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Processor think time of 0 to 3 cycles
  task automatic random_pause();
    int cycles;
    cycles = 0;
    repeat (2) begin
      lfsr   = lfsr_next(lfsr);
      cycles = cycles * 2 + int'(lfsr[0]);
    end
    repeat (cycles) @(posedge clk);
  endtask

  task automatic wait_ack(input logic level);
    @(negedge clk);
    while ((to_sw_sig == stat_ack) != level) @(negedge clk);
  endtask

  task automatic wait_status(input logic [1:0] want);
    @(negedge clk);
    while (to_sw_sig != want) @(negedge clk);
  endtask

  // One four-phase exchange, used for commands and for bytes
  task automatic handshake(input logic [1:0] flag, input logic [aes_io_pkg::byte_w-1:0] data);
    random_pause();
    @(posedge clk);
    to_hw_port <= data;
    to_hw_sig  <= flag;
    wait_ack(1'b1);
    random_pause();
    @(posedge clk);
    to_hw_sig <= 2'd0;
    wait_ack(1'b0);
  endtask

  task automatic load_block(input logic [1:0] cmd, input logic [aes_io_pkg::block_w-1:0] blk);
    handshake(cmd, '0);
    for (int i = 0; i < aes_io_pkg::block_bytes; i++) begin
      handshake(flag_req,
                blk[aes_io_pkg::block_w-1-i*aes_io_pkg::byte_w -: aes_io_pkg::byte_w]);
    end
  endtask

  task automatic request_block_check(input logic [aes_io_pkg::block_w-1:0] m,
                                     input logic [aes_io_pkg::block_w-1:0] k);
    @(posedge clk);
    exp_msg      <= m;
    exp_key      <= k;
    check_blocks <= 1'b1;
    @(posedge clk);
    check_blocks <= 1'b0;
  endtask

  task automatic request_result_check(input logic [aes_io_pkg::block_w-1:0] r);
    @(posedge clk);
    exp_result   <= r;
    check_result <= 1'b1;
    @(posedge clk);
    check_result <= 1'b0;
  endtask

  // Core stand-in, answers io_ready after the vector's delay with message XOR key
  initial begin : core_model
    forever begin
      @(negedge clk);
      if (io_ready) begin
        repeat (core_delay) @(posedge clk);
        @(posedge clk);
        msg_de    <= msg_en ^ key;
        aes_ready <= 1'b1;
        @(posedge clk);
        aes_ready <= 1'b0;
      end
    end
  end

  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", limit_cycles);
    $display("sim failed");
    $finish;
  end

  initial begin : main_seq
    logic [aes_io_pkg::block_w-1:0] msg_v;
    logic [aes_io_pkg::block_w-1:0] key_v;
    logic [aes_io_pkg::block_w-1:0] res_v;
    int                             delay_sum;
    reset_n      = 1'b0;
    to_hw_sig    = 2'd0;
    to_hw_port   = '0;
    msg_de       = '0;
    aes_ready    = 1'b0;
    exp_msg      = '0;
    exp_key      = '0;
    exp_result   = '0;
    check_blocks = 1'b0;
    check_result = 1'b0;
    core_delay   = 0;
    lfsr         = 32'hfb75513b;
    for (int i = 0; i < 4 * max_vecs; i++) begin
      vec_mem[i] = {1'b1, {aes_io_pkg::block_w{1'b0}}};
    end
    $readmemh("tests/aes_io_input.dat", vec_mem);
    n_vecs    = 0;
    delay_sum = 0;
    while (n_vecs < max_vecs && !vec_mem[4*n_vecs][aes_io_pkg::block_w]) begin
      delay_sum = delay_sum + int'(vec_mem[4*n_vecs+2][15:0]);
      n_vecs++;
    end
    if (n_vecs == 0) begin
      $display("No transactions were read from tests/aes_io_input.dat");
    end
    limit_cycles = reset_cycles + 16 + delay_sum + n_vecs * (exch_per_vec * cycles_per_exch + 16);

    repeat (reset_cycles) @(posedge clk);
    reset_n <= 1'b1;
    wait_status(stat_idle);

    for (int v = 0; v < n_vecs; v++) begin
      msg_v      = vec_mem[4*v][aes_io_pkg::block_w-1:0];
      key_v      = vec_mem[4*v+1][aes_io_pkg::block_w-1:0];
      core_delay = int'(vec_mem[4*v+2][15:0]);
      res_v      = vec_mem[4*v+3][aes_io_pkg::block_w-1:0];
      // Key from the previous transaction must survive the message load
      load_block(cmd_load_msg, msg_v);
      request_block_check(msg_v, exp_key);
      load_block(cmd_load_key, key_v);
      request_block_check(msg_v, key_v);
      handshake(cmd_run, '0);
      wait_status(stat_done);
      repeat (aes_io_pkg::block_bytes) handshake(flag_req, '0);
      request_result_check(res_v);
    end

    repeat (4) @(posedge clk);
    $display("Checks run: %0d, mismatches: %0d, handshake errors: %0d",
             check_count, mismatch_count, handshake_errors);
    if (n_vecs > 0 && check_count > 0 && mismatch_count == 0 && handshake_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: tests/aes_io_monitor.sv
// Checker for the AES host I/O bridge testbench, watches the DUT ports and counts errors
`timescale 1ns/1ps

module aes_io_monitor (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic [1:0]                      to_hw_sig,
  input  logic [1:0]                      to_sw_sig,
  input  logic [aes_io_pkg::byte_w-1:0]   to_sw_port,
  input  logic [aes_io_pkg::block_w-1:0]  msg_en,
  input  logic [aes_io_pkg::block_w-1:0]  key,
  input  logic                            io_ready,
  input  logic                            aes_ready,
  input  logic                            check_blocks,
  input  logic                            check_result,
  input  logic [aes_io_pkg::block_w-1:0]  exp_msg,
  input  logic [aes_io_pkg::block_w-1:0]  exp_key,
  input  logic [aes_io_pkg::block_w-1:0]  exp_result,
  output int                              check_count,
  output int                              mismatch_count,
  output int                              handshake_errors
);

  typedef logic [aes_io_pkg::block_w-1:0] word_t;

  // Status codes on to_sw_sig
  localparam logic [1:0] stat_idle  = 2'd0;
  localparam logic [1:0] stat_ack   = 2'd1;
  localparam logic [1:0] stat_done  = 2'd2;
  localparam logic [1:0] stat_reset = 2'd3;

  // Values seen at the previous falling edge
  logic [1:0] prev_sig;
  logic [1:0] prev_hw;
  logic       prev_ready;
  logic       prev_aes;

  word_t got_result;
  int    got_bytes;
  int    since_reset;

  task automatic compare(input string what, input word_t got, input word_t want);
    check_count++;
    if (got !== want) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic report_handshake(input string what);
    handshake_errors++;
    $display("Handshake error at %0t: %s", $time, what);
  endtask

  task automatic check_exchange();
    if (to_sw_sig == stat_ack && prev_sig != stat_ack && prev_hw == 2'd0) begin
      report_handshake("ack raised with no req from the processor");
    end
    if (prev_sig == stat_ack && prev_hw != 2'd0 && to_sw_sig != stat_ack) begin
      report_handshake("ack dropped while req was still raised");
    end
    if (to_sw_sig != stat_ack && to_sw_port != '0) begin
      compare("to_sw_port without ack", word_t'(to_sw_port), '0);
    end
    // Core start request must wait for the core
    if (prev_ready && !prev_aes && !io_ready) begin
      report_handshake("io_ready fell before the core raised aes_ready");
    end
    if (prev_ready && prev_aes) begin
      compare("io_ready after aes_ready", word_t'(io_ready), '0);
      compare("status after aes_ready", word_t'(to_sw_sig), word_t'(stat_done));
    end
    // Readback byte is taken when ack rises out of the done status
    if (prev_sig == stat_done && to_sw_sig == stat_ack) begin
      got_result = {got_result[aes_io_pkg::block_w-aes_io_pkg::byte_w-1:0], to_sw_port};
      got_bytes++;
    end
  endtask

  always @(negedge clk) begin
    if (!reset_n) begin
      since_reset = 0;
    end else begin
      since_reset = since_reset + 1;
      if (since_reset == 1) begin
        compare("status after reset", word_t'(to_sw_sig), word_t'(stat_reset));
        compare("io_ready after reset", word_t'(io_ready), '0);
        compare("msg_en after reset", msg_en, '0);
        compare("key after reset", key, '0);
      end else if (since_reset == 2) begin
        compare("status one cycle after reset", word_t'(to_sw_sig), word_t'(stat_idle));
      end else begin
        check_exchange();
      end
      if (check_blocks) begin
        compare("msg_en", msg_en, exp_msg);
        compare("key", key, exp_key);
      end
      if (check_result) begin
        compare("readback byte count", word_t'(got_bytes), word_t'(aes_io_pkg::block_bytes));
        compare("readback result", got_result, exp_result);
        got_bytes = 0;
      end
    end
    prev_sig   = to_sw_sig;
    prev_hw    = to_hw_sig;
    prev_ready = io_ready;
    prev_aes   = aes_ready;
  end

endmodule

// File: design/aes_io_bridge.sv
// Top of the host I/O bridge between the processor byte ports and the AES decryption core
`timescale 1ns/1ps

module aes_io_bridge (
  input  logic                             clk,
  input  logic                             reset_n,
  input  aes_io_pkg::host_cmd_t            to_hw_sig,
  input  logic [aes_io_pkg::byte_w-1:0]    to_hw_port,
  input  logic [aes_io_pkg::block_w-1:0]   msg_de,
  input  logic                             aes_ready,
  output aes_io_pkg::status_t              to_sw_sig,
  output logic [aes_io_pkg::byte_w-1:0]    to_sw_port,
  output logic [aes_io_pkg::block_w-1:0]   msg_en,
  output logic [aes_io_pkg::block_w-1:0]   key,
  output logic                             io_ready
);

  // Strobes and byte position from the machine to the buffer
  logic                              load_msg;
  logic                              load_key;
  logic                              send_byte;
  logic [aes_io_pkg::byte_idx_w-1:0] byte_idx;

  host_io_fsm u_fsm (
    .clk       (clk),
    .reset_n   (reset_n),
    .to_hw_sig (to_hw_sig),
    .aes_ready (aes_ready),
    .to_sw_sig (to_sw_sig),
    .io_ready  (io_ready),
    .load_msg  (load_msg),
    .load_key  (load_key),
    .send_byte (send_byte),
    .byte_idx  (byte_idx)
  );

  block_buffer u_buf (
    .clk        (clk),
    .reset_n    (reset_n),
    .to_hw_port (to_hw_port),
    .byte_idx   (byte_idx),
    .load_msg   (load_msg),
    .load_key   (load_key),
    .send_byte  (send_byte),
    .msg_de     (msg_de),
    .msg_en     (msg_en),
    .key        (key),
    .to_sw_port (to_sw_port)
  );

  // Core inputs do not move while the core is working
  run_stable_a: assert property (
    @(posedge clk) disable iff (!reset_n)
    (u_fsm.phase == aes_io_pkg::ph_run) |-> ($stable(msg_en) && $stable(key))
  );

  // A readback byte is only ever shown under ack
  port_under_ack_a: assert property (
    @(posedge clk) disable iff (!reset_n)
    (to_sw_port != '0) |-> (to_sw_sig == aes_io_pkg::stat_ack)
  );

endmodule

// File: design/block_buffer.sv
// Message and key registers loaded one byte per strobe, and the result byte selector
`timescale 1ns/1ps

module block_buffer (
  input  logic                               clk,
  input  logic                               reset_n,
  input  logic [aes_io_pkg::byte_w-1:0]      to_hw_port,
  input  logic [aes_io_pkg::byte_idx_w-1:0]  byte_idx,
  input  logic                               load_msg,
  input  logic                               load_key,
  input  logic                               send_byte,
  input  logic [aes_io_pkg::block_w-1:0]     msg_de,
  output logic [aes_io_pkg::block_w-1:0]     msg_en,
  output logic [aes_io_pkg::block_w-1:0]     key,
  output logic [aes_io_pkg::byte_w-1:0]      to_sw_port
);

  // Byte slot inside a block, counted from the least significant end
  logic [aes_io_pkg::byte_idx_w-1:0] slot;

  // Transfer order is most significant byte first,
  // and sixteen bytes fill the counter so the slot is its complement
  assign slot = ~byte_idx;

  // Replace one byte of a block and keep the rest
  function automatic logic [aes_io_pkg::block_w-1:0] put_byte(
    input logic [aes_io_pkg::block_w-1:0]    blk,
    input logic [aes_io_pkg::byte_idx_w-1:0] pos,
    input logic [aes_io_pkg::byte_w-1:0]     data
  );
    logic [aes_io_pkg::block_w-1:0] res;
    res = blk;
    res[pos*aes_io_pkg::byte_w +: aes_io_pkg::byte_w] = data;
    return res;
  endfunction

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      msg_en <= '0;
      key    <= '0;
    end else begin
      if (load_msg) begin
        msg_en <= put_byte(msg_en, slot, to_hw_port);
      end
      if (load_key) begin
        key <= put_byte(key, slot, to_hw_port);
      end
    end
  end

  // Outbound byte, quiet unless the machine is acking a readback byte
  always_comb begin
    to_sw_port = '0;
    if (send_byte) begin
      to_sw_port = msg_de[slot*aes_io_pkg::byte_w +: aes_io_pkg::byte_w];
    end
  end

  // Only one block is being loaded at a time
  one_load_a: assert property (
    @(posedge clk) disable iff (!reset_n)
    !(load_msg && load_key)
  );

endmodule

// File: design/host_io_fsm.sv
// Phase machine for the processor req/ack exchange and the start/done exchange with the core
`timescale 1ns/1ps

module host_io_fsm (
  input  logic                                clk,
  input  logic                                reset_n,
  input  aes_io_pkg::host_cmd_t               to_hw_sig,
  input  logic                                aes_ready,
  output aes_io_pkg::status_t                 to_sw_sig,
  output logic                                io_ready,
  output logic                                load_msg,
  output logic                                load_key,
  output logic                                send_byte,
  output logic [aes_io_pkg::byte_idx_w-1:0]   byte_idx
);

  aes_io_pkg::io_phase_t phase;
  aes_io_pkg::io_phase_t next_phase;

  // Command accepted in idle, kept until the machine is back in idle
  aes_io_pkg::host_cmd_t pending_cmd;
  aes_io_pkg::host_cmd_t next_cmd;

  logic req_seen;
  logic req_released;
  logic last_byte;
  logic ack_phase;

  assign req_seen     = (to_hw_sig == aes_io_pkg::sig_req);
  assign req_released = (to_hw_sig == aes_io_pkg::sig_release);
  assign last_byte    = (int'(byte_idx) == aes_io_pkg::block_bytes - 1);

  // Per-byte ack phases, the counter moves when req is dropped here
  assign ack_phase = (phase == aes_io_pkg::ph_byte_ack) ||
                     (phase == aes_io_pkg::ph_send_ack);

  always_comb begin
    next_phase = phase;
    next_cmd   = pending_cmd;
    unique case (phase)
      aes_io_pkg::ph_reset: begin
        next_phase = aes_io_pkg::ph_idle;
      end
      aes_io_pkg::ph_idle: begin
        if (to_hw_sig != aes_io_pkg::cmd_none) begin
          next_cmd   = to_hw_sig;
          next_phase = aes_io_pkg::ph_cmd_release;
        end
      end
      aes_io_pkg::ph_cmd_release: begin
        // Enter the requested phase once the command flag is withdrawn
        if (req_released) begin
          case (pending_cmd)
            aes_io_pkg::cmd_load_msg: next_phase = aes_io_pkg::ph_load_msg;
            aes_io_pkg::cmd_load_key: next_phase = aes_io_pkg::ph_load_key;
            aes_io_pkg::cmd_run:      next_phase = aes_io_pkg::ph_run;
            default:                  next_phase = aes_io_pkg::ph_idle;
          endcase
        end
      end
      aes_io_pkg::ph_load_msg,
      aes_io_pkg::ph_load_key: begin
        if (req_seen) begin
          next_phase = aes_io_pkg::ph_byte_ack;
        end
      end
      aes_io_pkg::ph_byte_ack: begin
        if (req_released) begin
          if (last_byte) begin
            next_phase = aes_io_pkg::ph_idle;
          end else if (pending_cmd == aes_io_pkg::cmd_load_key) begin
            next_phase = aes_io_pkg::ph_load_key;
          end else begin
            next_phase = aes_io_pkg::ph_load_msg;
          end
        end
      end
      aes_io_pkg::ph_run: begin
        // Core may take any number of cycles
        if (aes_ready) begin
          next_phase = aes_io_pkg::ph_result;
        end
      end
      aes_io_pkg::ph_result: begin
        if (req_seen) begin
          next_phase = aes_io_pkg::ph_send_ack;
        end
      end
      aes_io_pkg::ph_send_ack: begin
        if (req_released) begin
          next_phase = last_byte ? aes_io_pkg::ph_idle : aes_io_pkg::ph_result;
        end
      end
      default: begin
        next_phase = aes_io_pkg::ph_idle;
      end
    endcase

    if (next_phase == aes_io_pkg::ph_idle) begin
      next_cmd = aes_io_pkg::cmd_none;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      phase       <= aes_io_pkg::ph_reset;
      pending_cmd <= aes_io_pkg::cmd_none;
      byte_idx    <= '0;
      io_ready    <= 1'b0;
    end else begin
      phase       <= next_phase;
      pending_cmd <= next_cmd;
      // Start request to the core is a register so it has no glitches
      io_ready    <= (next_phase == aes_io_pkg::ph_run);
      if (next_phase == aes_io_pkg::ph_idle) begin
        byte_idx <= '0;
      end else if (ack_phase && req_released) begin
        byte_idx <= byte_idx + 1'b1;
      end
    end
  end

  // Status flag is decoded from the phase alone
  always_comb begin
    case (phase)
      aes_io_pkg::ph_reset:       to_sw_sig = aes_io_pkg::stat_reset;
      aes_io_pkg::ph_cmd_release: to_sw_sig = aes_io_pkg::stat_ack;
      aes_io_pkg::ph_byte_ack:    to_sw_sig = aes_io_pkg::stat_ack;
      aes_io_pkg::ph_send_ack:    to_sw_sig = aes_io_pkg::stat_ack;
      aes_io_pkg::ph_result:      to_sw_sig = aes_io_pkg::stat_done;
      default:                    to_sw_sig = aes_io_pkg::stat_idle;
    endcase
  end

  // Write strobes fire on the edge that samples req, together with the move to ack
  assign load_msg  = (phase == aes_io_pkg::ph_load_msg) && req_seen;
  assign load_key  = (phase == aes_io_pkg::ph_load_key) && req_seen;
  assign send_byte = (phase == aes_io_pkg::ph_send_ack);

  // Ack is held for as long as the processor keeps its flag raised
  ack_held_a: assert property (
    @(posedge clk) disable iff (!reset_n)
    (to_sw_sig == aes_io_pkg::stat_ack && to_hw_sig != aes_io_pkg::sig_release)
      |=> (to_sw_sig == aes_io_pkg::stat_ack)
  );

  // Start request stays up until the core answers and drops right after
  ready_until_core_a: assert property (
    @(posedge clk) disable iff (!reset_n)
    io_ready |=> (io_ready == !$past(aes_ready))
  );

endmodule

// File: design/aes_io_pkg.sv
// Widths, handshake codes and phase encoding shared by the AES host I/O bridge RTL
package aes_io_pkg;

  // Data port and block geometry, fixed by AES-128
  localparam int byte_w      = 8;
  localparam int block_w     = 128;
  localparam int block_bytes = block_w / byte_w;
  localparam int byte_idx_w  = 4;

  // Processor to hardware flag
  // While idle it carries a command, inside a phase it is the req line
  typedef logic [1:0] host_cmd_t;

  localparam host_cmd_t cmd_none     = 2'd0;
  localparam host_cmd_t cmd_load_msg = 2'd1;
  localparam host_cmd_t cmd_load_key = 2'd2;
  localparam host_cmd_t cmd_run      = 2'd3;

  // Per-byte req levels used once a phase has been entered
  localparam host_cmd_t sig_release  = 2'd0;
  localparam host_cmd_t sig_req      = 2'd1;

  // Hardware to processor flag
  typedef enum logic [1:0] {
    stat_idle  = 2'd0,
    stat_ack   = 2'd1,
    stat_done  = 2'd2,
    stat_reset = 2'd3
  } status_t;

  // Phases of the host I/O machine
  typedef enum logic [3:0] {
    ph_reset,
    ph_idle,
    ph_cmd_release,
    ph_load_msg,
    ph_load_key,
    ph_byte_ack,
    ph_run,
    ph_result,
    ph_send_ack
  } io_phase_t;

endpackage
